//--- build.f
+incdir+src
src/isaPkg.sv
src/aluPkg.sv
src/aluCtrlIf.sv
src/instrDecoder.sv
src/barrelShifter.sv
src/aluCore.sv
src/resultStage.sv
src/execUnit.sv
dv/tbExecUnit.sv

//--- Makefile
TOP := tbExecUnit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# Pass only when the pass line shows up in the simulation output
sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- dv/tbExecUnit.sv
`timescale 1ns/10ps
`default_nettype none

module tbExecUnit;

	logic        clk;
	logic        rstN;
	logic        instrValid;
	logic [15:0] instr;
	logic [15:0] rsData;
	logic [15:0] rtData;
	logic        resultValid;
	logic [15:0] result;
	logic        zero;
	logic        signFlag;
	logic        ofl;
	logic        cout;
	logic        illegal;
	int          seed;

	// Opcodes from the instruction set
	localparam logic [4:0] opcAlu   = 5'b11011;
	localparam logic [4:0] opcShift = 5'b11010;
	localparam logic [4:0] opcBtr   = 5'b11001;
	localparam logic [4:0] opcSco   = 5'b11111;
	localparam logic [4:0] opcAddi  = 5'b01000;
	localparam logic [4:0] opcSubi  = 5'b01001;
	localparam logic [4:0] opcXori  = 5'b01010;
	localparam logic [4:0] opcAndni = 5'b01011;
	localparam logic [4:0] opcSlbi  = 5'b10010;

	execUnit dut (.*);

	// 8 ns period
	always #4 clk = ~clk;

	task automatic checkEq(input logic [15:0] got, input logic [15:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("Regression failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	function automatic logic [15:0] randWord();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// rs field 1, rt field 2, never used by the DUT
	function automatic logic [15:0] encodeR(input logic [4:0] opc, input logic [1:0] fn);
		return {opc, 3'd1, 3'd2, 3'd0, fn};
	endfunction

	function automatic logic [15:0] encodeI(input logic [4:0] opc, input logic [4:0] imm);
		return {opc, 3'd1, 3'd2, imm};
	endfunction

	function automatic logic [15:0] mirror(input logic [15:0] v);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = v[15 - i];
		end
		return r;
	endfunction

	// Kind 0 ROL, 1 SLL, 2 ROR, 3 SRL
	function automatic logic [15:0] shiftRef(input logic [15:0] v, input logic [3:0] amt,
			input logic [1:0] kind);
		logic [31:0] rotL;
		logic [31:0] rotR;
		logic [15:0] r;
		rotL = {v, v} << amt;
		rotR = {v, v} >> amt;
		case (kind)
			2'd0:    r = rotL[31:16];
			2'd1:    r = v << amt;
			2'd2:    r = rotR[15:0];
			default: r = v >> amt;
		endcase
		return r;
	endfunction

	task automatic addRef(input logic [15:0] x, y, output logic [15:0] s, output logic o, c);
		logic [16:0] w;
		w = {1'b0, x} + {1'b0, y};
		s = w[15:0];
		c = w[16];
		// Same-sign inputs, result sign flipped
		o = (x[15] == y[15]) && (s[15] != x[15]);
	endtask

	// x minus y, carry means no borrow
	task automatic subRef(input logic [15:0] x, y, output logic [15:0] s, output logic o, c);
		s = x - y;
		c = (x >= y);
		o = (x[15] != y[15]) && (s[15] != x[15]);
	endtask

	// Reference model from the ISA rules
	task automatic computeExpected(input logic [15:0] ins, rs, rt, output logic [15:0] res,
			output logic o, c, ill);
		logic [15:0] sImm;
		logic [15:0] zImm;
		logic [15:0] scratch;
		sImm = {{11{ins[4]}}, ins[4:0]};
		zImm = {11'd0, ins[4:0]};
		res  = 16'h0;
		o    = 1'b0;
		c    = 1'b0;
		ill  = 1'b0;
		case (ins[15:11])
			opcAlu: begin
				case (ins[1:0])
					2'b00:   addRef(rs, rt, res, o, c);
					2'b01:   subRef(rt, rs, res, o, c);
					2'b10:   res = rs ^ rt;
					default: res = rs & ~rt;
				endcase
			end
			opcShift: res = shiftRef(rs, rt[3:0], ins[1:0]);
			opcBtr:   res = mirror(rs);
			// Set instructions, plain signed compares
			5'b11100: res = {15'd0, rs == rt};
			5'b11101: res = {15'd0, $signed(rs) < $signed(rt)};
			5'b11110: res = {15'd0, $signed(rs) <= $signed(rt)};
			opcSco: begin
				addRef(rs, rt, scratch, o, c);
				res = {15'd0, c};
			end
			opcAddi:  addRef(rs, sImm, res, o, c);
			opcSubi:  subRef(sImm, rs, res, o, c);
			opcXori:  res = rs ^ zImm;
			opcAndni: res = rs & ~zImm;
			5'b10100, 5'b10101, 5'b10110, 5'b10111: res = shiftRef(rs, ins[3:0], ins[12:11]);
			opcSlbi:  res = {rs[7:0], ins[7:0]};
			default:  ill = 1'b1;
		endcase
	endtask

	task automatic runInstr(input logic [15:0] ins, rs, rt, input string name);
		logic [15:0] expRes;
		logic        expOfl;
		logic        expCout;
		logic        expIll;
		int          cycles;
		computeExpected(ins, rs, rt, expRes, expOfl, expCout, expIll);
		@(posedge clk);
		#1;
		instr      = ins;
		rsData     = rs;
		rtData     = rt;
		instrValid = 1'b1;
		cycles     = 0;
		// Single strobe, then wait for the pulse
		do begin
			@(posedge clk);
			#1;
			instrValid = 1'b0;
			cycles++;
			if (cycles > 8) begin
				$display("Timeout: no result appeared for %s", name);
				$display("Regression failed");
				$fatal(1, "Result timeout");
			end
		end while (!resultValid);
		checkEq(16'(cycles), 16'd1, {name, " latency"});
		checkEq(result, expRes, {name, " result"});
		checkEq(16'(illegal), 16'(expIll), {name, " illegal"});
		checkEq(16'(zero), 16'(expRes == 16'h0), {name, " zero"});
		checkEq(16'(signFlag), 16'(expRes[15]), {name, " signFlag"});
		checkEq(16'(ofl), 16'(expOfl), {name, " ofl"});
		checkEq(16'(cout), 16'(expCout), {name, " cout"});
	endtask

	task automatic arithOps();
		logic [15:0] a;
		logic [15:0] b;
		// Edge operands
		runInstr(encodeR(opcAlu, 2'b00), 16'h7fff, 16'h0001, "ADD 7fff+1");
		runInstr(encodeR(opcAlu, 2'b00), 16'hffff, 16'h0001, "ADD ffff+1");
		runInstr(encodeR(opcAlu, 2'b01), 16'h0001, 16'h8000, "SUB 8000-1");
		runInstr(encodeR(opcAlu, 2'b01), 16'h1234, 16'h1234, "SUB equal");
		runInstr(encodeI(opcAddi, 5'h01), 16'h7fff, 16'h0, "ADDI 7fff+1");
		runInstr(encodeI(opcAddi, 5'h1f), 16'h0001, 16'h0, "ADDI 1-1");
		runInstr(encodeI(opcSubi, 5'h1f), 16'h8000, 16'h0, "SUBI -1-8000");
		for (int i = 0; i < 16; i++) begin
			a = randWord();
			b = randWord();
			runInstr(encodeR(opcAlu, 2'b00), a, b, "ADD random");
			runInstr(encodeR(opcAlu, 2'b01), a, b, "SUB random");
			runInstr(encodeI(opcAddi, b[4:0]), a, b, "ADDI random");
			runInstr(encodeI(opcSubi, b[4:0]), a, b, "SUBI random");
		end
	endtask

	task automatic logicOps();
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < 16; i++) begin
			a = randWord();
			b = randWord();
			runInstr(encodeR(opcAlu, 2'b10), a, b, "XOR random");
			runInstr(encodeR(opcAlu, 2'b11), a, b, "ANDN random");
			// Top immediate bit set checks zero extension
			runInstr(encodeI(opcXori, {1'b1, b[3:0]}), a, b, "XORI random");
			runInstr(encodeI(opcAndni, {1'b1, b[3:0]}), a, b, "ANDNI random");
		end
	endtask

	task automatic shiftOps();
		logic [15:0] a;
		logic [15:0] b;
		for (int amt = 0; amt < 16; amt++) begin
			for (int kind = 0; kind < 4; kind++) begin
				a = randWord();
				b = randWord();
				b[3:0] = amt[3:0];
				runInstr(encodeR(opcShift, kind[1:0]), a, b,
					$sformatf("shift kind %0d by %0d", kind, amt));
				runInstr(encodeI({3'b101, kind[1:0]}, b[4:0]), a, b,
					$sformatf("shift imm kind %0d by %0d", kind, amt));
			end
		end
	endtask

	task automatic slbiAndBtr();
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < 12; i++) begin
			a = randWord();
			b = randWord();
			runInstr({opcSlbi, 3'd1, b[7:0]}, a, b, "SLBI random");
			runInstr(encodeR(opcBtr, 2'b00), a, b, "BTR random");
		end
	endtask

	task automatic setConditions();
		logic [15:0] pairRs [7] = '{16'h0005, 16'h0007, 16'h0003, 16'h8000,
			16'h7fff, 16'hffff, 16'hfffe};
		logic [15:0] pairRt [7] = '{16'h0005, 16'h0003, 16'h0007, 16'h7fff,
			16'h8000, 16'h0001, 16'hffff};
		for (int p = 0; p < 7; p++) begin
			// SEQ, SLT, SLE, SCO in opcode order
			for (int k = 0; k < 4; k++) begin
				runInstr(encodeR({3'b111, k[1:0]}, 2'b00), pairRs[p], pairRt[p],
					$sformatf("set op %0d pair %0d", k, p));
			end
		end
	endtask

	task automatic illegalAndBurst();
		logic [15:0] insQ [4];
		logic [15:0] rsQ [4];
		logic [15:0] rtQ [4];
		logic [15:0] expQ [4];
		logic        eo;
		logic        ec;
		logic        ei;
		// Whole opcode space, illegal ones included
		for (int opc = 0; opc < 32; opc++) begin
			runInstr(encodeI(opc[4:0], 5'h0b), randWord(), randWord(),
				$sformatf("opcode %b", opc[4:0]));
		end
		insQ = '{encodeR(opcAlu, 2'b00), encodeR(opcShift, 2'b01),
			encodeR(opcBtr, 2'b00), encodeI(opcXori, 5'h15)};
		for (int i = 0; i < 4; i++) begin
			rsQ[i] = randWord();
			rtQ[i] = randWord();
			computeExpected(insQ[i], rsQ[i], rtQ[i], expQ[i], eo, ec, ei);
		end
		// Back to back, result due one cycle after each strobe
		for (int i = 0; i <= 4; i++) begin
			@(posedge clk);
			#1;
			if (i > 0) begin
				checkEq(16'(resultValid), 16'd1, $sformatf("back-to-back valid %0d", i - 1));
				checkEq(result, expQ[i - 1], $sformatf("back-to-back result %0d", i - 1));
			end
			if (i < 4) begin
				instr      = insQ[i];
				rsData     = rsQ[i];
				rtData     = rtQ[i];
				instrValid = 1'b1;
			end else begin
				instrValid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		checkEq(16'(resultValid), 16'd0, "valid drops after burst");
	endtask

	initial begin
		seed       = 32'h69e982ac;
		clk        = 1'b0;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = 16'h0;
		rsData     = 16'h0;
		rtData     = 16'h0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		// Reset values
		checkEq(16'(resultValid), 16'd0, "resultValid after reset");
		checkEq(result, 16'h0, "result after reset");
		checkEq(16'(illegal), 16'd0, "illegal after reset");
		checkEq(16'(zero), 16'd0, "zero after reset");
		checkEq(16'(signFlag), 16'd0, "signFlag after reset");
		checkEq(16'(ofl), 16'd0, "ofl after reset");
		checkEq(16'(cout), 16'd0, "cout after reset");
		arithOps();
		logicOps();
		shiftOps();
		slbiAndBtr();
		setConditions();
		illegalAndBurst();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit (
	input  logic             clk,
	input  logic             rstN,
	input  logic             instrValid,
	input  isaPkg::instrWord instr,
	input  aluPkg::dataWord  rsData,
	input  aluPkg::dataWord  rtData,
	output logic             resultValid,
	output aluPkg::dataWord  result,
	output logic             zero,
	output logic             signFlag,
	output logic             ofl,
	output logic             cout,
	output logic             illegal
);
	import aluPkg::*;

	// Decoded controls shared by core and result stage
	aluCtrlIf ctrlBus ();

	// Raw ALU outputs, same cycle as the instruction
	dataWord aluOut;
	logic    aluOfl;
	logic    aluCout;

	instrDecoder decoder (
		.instr      (instr),
		.instrValid (instrValid),
		.rsData     (rsData),
		.rtData     (rtData),
		.ctrl       (ctrlBus.dec)
	);

	aluCore core (
		.ctrl    (ctrlBus.exe),
		.aluOut  (aluOut),
		.aluOfl  (aluOfl),
		.aluCout (aluCout)
	);

	// Registered outputs, one cycle after instrValid
	resultStage resStage (
		.clk         (clk),
		.rstN        (rstN),
		.ctrl        (ctrlBus.res),
		.aluOut      (aluOut),
		.aluOfl      (aluOfl),
		.aluCout     (aluCout),
		.resultValid (resultValid),
		.result      (result),
		.zero        (zero),
		.signFlag    (signFlag),
		.ofl         (ofl),
		.cout        (cout),
		.illegal     (illegal)
	);

endmodule

`default_nettype wire

//--- src/resultStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_macros.svh"

module resultStage (
	input  logic            clk,
	input  logic            rstN,
	aluCtrlIf.res           ctrl,
	input  aluPkg::dataWord aluOut,
	input  logic            aluOfl,
	input  logic            aluCout,
	output logic            resultValid,
	output aluPkg::dataWord result,
	output logic            zero,
	output logic            signFlag,
	output logic            ofl,
	output logic            cout,
	output logic            illegal
);
	import aluPkg::*;

	logic    diffZero;
	logic    sleHit;
	logic    setBit;
	dataWord finalVal;

	// Compares see rt-rs on aluOut
	assign diffZero = (aluOut == '0);
	// Signed rt-rs non-negative
	assign sleHit   = ~(aluOut[`WISC_DATA_W-1] ^ aluOfl);

	always_comb begin
		case (ctrl.cond)
			condEq:  setBit = diffZero;
			condLt:  setBit = sleHit & ~diffZero;
			condLe:  setBit = sleHit;
			condCo:  setBit = aluCout;
			default: setBit = 1'b0;
		endcase
		// Illegal forces zero, set instructions write 0 or 1
		if (ctrl.illegal) begin
			finalVal = '0;
		end else if (ctrl.cond != condNone) begin
			finalVal = dataWord'(setBit);
		end else begin
			finalVal = aluOut;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			result      <= '0;
			zero        <= 1'b0;
			signFlag    <= 1'b0;
			ofl         <= 1'b0;
			cout        <= 1'b0;
			illegal     <= 1'b0;
		end else begin
			// One-cycle pulse per accepted instruction
			resultValid <= ctrl.valid;
			if (ctrl.valid) begin
				result   <= finalVal;
				zero     <= (finalVal == '0);
				signFlag <= finalVal[`WISC_DATA_W-1];
				// Adder flags only for add/sub and SCO
				ofl      <= ctrl.isArith & aluOfl;
				cout     <= ctrl.isArith & aluCout;
				illegal  <= ctrl.illegal;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/aluCore.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_macros.svh"

module aluCore (
	aluCtrlIf.exe           ctrl,
	output aluPkg::dataWord aluOut,
	output logic            aluOfl,
	output logic            aluCout
);
	import aluPkg::*;

	dataWord                a;
	dataWord                b;
	logic [`WISC_DATA_W:0]  sumExt;
	dataWord                sum;
	logic                   carryMsb;
	dataWord                shiftOut;
	logic                   shRight;
	logic                   shRotate;
	dataWord                slbiOut;

	// Operand inversion
	assign a = ctrl.invA ? ~ctrl.opA : ctrl.opA;
	assign b = ctrl.invB ? ~ctrl.opB : ctrl.opB;

	// 17-bit add, top bit is the carry out
	assign sumExt  = {1'b0, a} + {1'b0, b} + {{`WISC_DATA_W{1'b0}}, ctrl.cin};
	assign sum     = sumExt[`WISC_DATA_W-1:0];
	assign aluCout = sumExt[`WISC_DATA_W];

	// Carry into the MSB recovered from the sum bit
	assign carryMsb = a[`WISC_DATA_W-1] ^ b[`WISC_DATA_W-1] ^ sum[`WISC_DATA_W-1];
	// Signed overflow when carry in and out of the MSB differ
	assign aluOfl   = carryMsb ^ aluCout;

	// Shifter direction and fill from the op
	assign shRight  = (ctrl.op == opRor) || (ctrl.op == opSrl);
	assign shRotate = (ctrl.op == opRol) || (ctrl.op == opRor);

	barrelShifter shifter (
		.in     (a),
		.shAmt  (b[`WISC_SHAMT_W-1:0]),
		.dir    (shRight),
		.rotate (shRotate),
		.out    (shiftOut)
	);

	// rs moved up a byte, immediate ORed into the low byte
	assign slbiOut = {a[`WISC_DATA_W-9:0], 8'h00} | b;

	// Output select
	always_comb begin
		case (ctrl.op)
			opRol, opSll, opRor, opSrl: aluOut = shiftOut;
			opAdd:   aluOut = sum;
			opXor:   aluOut = a ^ b;
			opAnd:   aluOut = a & b;
			opSlbi:  aluOut = slbiOut;
			opBtr:   aluOut = reverseBits(a);
			default: aluOut = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/barrelShifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_macros.svh"

module barrelShifter (
	input  aluPkg::dataWord          in,
	input  logic [`WISC_SHAMT_W-1:0] shAmt,
	// 1 shifts right
	input  logic                     dir,
	// 1 wraps bits around, 0 fills zeros
	input  logic                     rotate,
	output aluPkg::dataWord          out
);
	import aluPkg::*;

	dataWord stIn;
	dataWord st1;
	dataWord st2;
	dataWord st4;
	dataWord st8;

	// Right shifts run as left shifts on the mirrored word
	assign stIn = dir ? reverseBits(in) : in;

	// By 1
	assign st1 = shAmt[0] ?
		{stIn[`WISC_DATA_W-2:0], rotate ? stIn[`WISC_DATA_W-1] : 1'b0} : stIn;

	// By 2
	assign st2 = shAmt[1] ?
		{st1[`WISC_DATA_W-3:0], rotate ? st1[`WISC_DATA_W-1 -: 2] : 2'b00} : st1;

	// By 4
	assign st4 = shAmt[2] ?
		{st2[`WISC_DATA_W-5:0], rotate ? st2[`WISC_DATA_W-1 -: 4] : 4'h0} : st2;

	// By 8
	assign st8 = shAmt[3] ?
		{st4[`WISC_DATA_W-9:0], rotate ? st4[`WISC_DATA_W-1 -: 8] : 8'h00} : st4;

	// Mirror back for right shifts
	assign out = dir ? reverseBits(st8) : st8;

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_macros.svh"

module instrDecoder (
	input  isaPkg::instrWord instr,
	input  logic             instrValid,
	input  aluPkg::dataWord  rsData,
	input  aluPkg::dataWord  rtData,
	aluCtrlIf.dec            ctrl
);
	import isaPkg::*;
	import aluPkg::*;

	opcode   opc;
	funcCode func;
	imm5     immS;
	imm8     immL;
	dataWord immSext;
	dataWord immZext5;
	dataWord immZext8;

	// Instruction fields
	assign opc  = opcode'(instr[`WISC_DATA_W-1 -: `WISC_OPC_W]);
	assign func = instr[1:0];
	assign immS = instr[4:0];
	assign immL = instr[7:0];

	// Immediate extensions
	assign immSext  = {{(`WISC_DATA_W-5){immS[4]}}, immS};
	assign immZext5 = {{(`WISC_DATA_W-5){1'b0}}, immS};
	assign immZext8 = {{(`WISC_DATA_W-8){1'b0}}, immL};

	// rs always feeds operand A
	assign ctrl.valid = instrValid;
	assign ctrl.opA   = rsData;

	always_comb begin
		// Defaults, plain rs+rt
		ctrl.illegal = 1'b0;
		ctrl.op      = opAdd;
		ctrl.opB     = rtData;
		ctrl.invA    = 1'b0;
		ctrl.invB    = 1'b0;
		ctrl.cin     = 1'b0;
		ctrl.isArith = 1'b0;
		ctrl.cond    = condNone;
		case (opc)
			opcAlu: begin
				case (func)
					// ADD
					2'b00: ctrl.isArith = 1'b1;
					// SUB is rt-rs, so rs gets inverted
					2'b01: begin
						ctrl.invA    = 1'b1;
						ctrl.cin     = 1'b1;
						ctrl.isArith = 1'b1;
					end
					2'b10: ctrl.op = opXor;
					// ANDN
					default: begin
						ctrl.op   = opAnd;
						ctrl.invB = 1'b1;
					end
				endcase
			end
			// Shift amount taken from rt[3:0] in the core
			opcShift: begin
				case (func)
					2'b00:   ctrl.op = opRol;
					2'b01:   ctrl.op = opSll;
					2'b10:   ctrl.op = opRor;
					default: ctrl.op = opSrl;
				endcase
			end
			opcBtr: ctrl.op = opBtr;
			// Compares all run rt-rs through the adder
			opcSeq, opcSlt, opcSle: begin
				ctrl.invA = 1'b1;
				ctrl.cin  = 1'b1;
				ctrl.cond = (opc == opcSeq) ? condEq : (opc == opcSlt) ? condLt : condLe;
			end
			// Carry out of rs+rt
			opcSco: begin
				ctrl.cond    = condCo;
				ctrl.isArith = 1'b1;
			end
			opcAddi: begin
				ctrl.opB     = immSext;
				ctrl.isArith = 1'b1;
			end
			// imm-rs
			opcSubi: begin
				ctrl.opB     = immSext;
				ctrl.invA    = 1'b1;
				ctrl.cin     = 1'b1;
				ctrl.isArith = 1'b1;
			end
			opcXori: begin
				ctrl.opB = immZext5;
				ctrl.op  = opXor;
			end
			opcAndni: begin
				ctrl.opB  = immZext5;
				ctrl.op   = opAnd;
				ctrl.invB = 1'b1;
			end
			opcRoli, opcSlli, opcRori, opcSrli: begin
				ctrl.opB = immZext5;
				// Low opcode bits line up with the shifter op codes
				ctrl.op  = aluOp'({2'b00, instr[`WISC_DATA_W-`WISC_OPC_W+1 -: 2]});
			end
			opcSlbi: begin
				ctrl.opB = immZext8;
				ctrl.op  = opSlbi;
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- src/aluCtrlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface aluCtrlIf;
	import aluPkg::*;

	// Instruction present this cycle
	logic    valid;
	// Opcode not in the ISA
	logic    illegal;
	// ALU operation and operands before inversion
	aluOp    op;
	dataWord opA;
	dataWord opB;
	// Adder controls, invert plus carry-in gives subtract
	logic    invA;
	logic    invB;
	logic    cin;
	// Adder flags are reported only when set
	logic    isArith;
	// Set-instruction selector
	setCond  cond;

	modport dec (output valid, illegal, op, opA, opB, invA, invB, cin, isArith, cond);
	modport exe (input op, opA, opB, invA, invB, cin);
	modport res (input valid, illegal, isArith, cond);

endinterface

`default_nettype wire

//--- src/aluPkg.sv
`default_nettype none

`include "wisc_macros.svh"

package aluPkg;

	// Operand or result word
	typedef logic [`WISC_DATA_W-1:0] dataWord;

	// Shifter ops first, low bits map onto direction and fill
	typedef enum logic [3:0] {
		opRol  = 4'b0000,
		opSll  = 4'b0001,
		opRor  = 4'b0010,
		opSrl  = 4'b0011,
		opAdd  = 4'b0100,
		opXor  = 4'b0101,
		opAnd  = 4'b0110,
		opSlbi = 4'b1000,
		opBtr  = 4'b1001
	} aluOp;

	// Which set-instruction result replaces the ALU output
	typedef enum logic [2:0] {
		condNone = 3'd0,
		condEq   = 3'd1,
		condLt   = 3'd2,
		condLe   = 3'd3,
		condCo   = 3'd4
	} setCond;

	// MSB to LSB mirror, BTR and the right-shift path
	function automatic dataWord reverseBits(input dataWord val);
		dataWord rev;
		for (int i = 0; i < `WISC_DATA_W; i++) begin
			rev[i] = val[`WISC_DATA_W-1-i];
		end
		return rev;
	endfunction

endpackage

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

`include "wisc_macros.svh"

package isaPkg;

	// Raw instruction word
	typedef logic [`WISC_DATA_W-1:0] instrWord;

	// Register specifier, rs and rt fields
	typedef logic [2:0] regIdx;

	// Immediate fields, I-format and SLBI
	typedef logic [4:0] imm5;
	typedef logic [7:0] imm8;

	// Low two bits select the R-format variant
	typedef logic [1:0] funcCode;

	// Legal opcodes only, anything else is illegal
	typedef enum logic [`WISC_OPC_W-1:0] {
		// I-format arithmetic and logic
		opcAddi  = 5'b01000,
		opcSubi  = 5'b01001,
		opcXori  = 5'b01010,
		opcAndni = 5'b01011,
		// SLBI with the 8-bit immediate
		opcSlbi  = 5'b10010,
		// I-format shifts and rotates
		opcRoli  = 5'b10100,
		opcSlli  = 5'b10101,
		opcRori  = 5'b10110,
		opcSrli  = 5'b10111,
		// R-format group
		opcBtr   = 5'b11001,
		opcShift = 5'b11010,
		opcAlu   = 5'b11011,
		// Set on condition
		opcSeq   = 5'b11100,
		opcSlt   = 5'b11101,
		opcSle   = 5'b11110,
		opcSco   = 5'b11111
	} opcode;

endpackage

`default_nettype wire

//--- src/wisc_macros.svh
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

// Machine word, also the instruction width
`define WISC_DATA_W 16

// Major opcode field in the top bits of the instruction
`define WISC_OPC_W 5

// Shift amount, enough for 0 to 15
`define WISC_SHAMT_W 4

`endif
